/* include/traffic_settings.svh */
`ifndef TRAFFIC_SETTINGS_SVH
`define TRAFFIC_SETTINGS_SVH

// Clock cycles between two seconds ticks
`define SEC_DIV 64

// Clock cycles between two row-scan ticks
`define SCAN_DIV 4

// Starting digit of each phase, limited to 0..5 by the glyph table
`define RED_TIME 5
`define GREEN_TIME 5
`define YELLOW_TIME 2

`endif

/* source/traffic_pkg.sv */
`default_nettype none

package traffic_pkg;

    // Light phases in the order the sequencer walks them
    typedef enum logic [1:0] {
        PH_RED    = 2'd0,
        PH_GREEN  = 2'd1,
        PH_YELLOW = 2'd2
    } phase_t;

    typedef logic [2:0] count_t;  // Countdown digit shown on the matrix

endpackage

`default_nettype wire

/* source/display_pkg.sv */
`default_nettype none

package display_pkg;

    typedef logic [2:0] row_idx_t;  // Matrix row 0..7

    // Bit 7 drives the leftmost column
    typedef logic [7:0] pattern_t;

    // Channels lit for the current digit
    typedef enum logic [1:0] {
        COL_RED   = 2'd0,
        COL_GREEN = 2'd1,
        COL_BOTH  = 2'd2
    } color_t;

endpackage

`default_nettype wire

/* source/tick_generator.sv */
`timescale 1ns/100ps
`default_nettype none
`include "traffic_settings.svh"

module tick_generator (
    input  logic clk,
    input  logic rst,
    output logic sec_tick,
    output logic scan_tick
);

    localparam int SEC_W  = $clog2(`SEC_DIV);
    localparam int SCAN_W = $clog2(`SCAN_DIV);

    logic [SEC_W-1:0]  sec_cnt;
    logic [SCAN_W-1:0] scan_cnt;
    logic              sec_wrap;
    logic              scan_wrap;

    assign sec_wrap  = (sec_cnt == SEC_W'(`SEC_DIV - 1));
    assign scan_wrap = (scan_cnt == SCAN_W'(`SCAN_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sec_cnt  <= '0;
            sec_tick <= 1'b0;
        end
        else
        begin
            sec_cnt  <= sec_wrap ? '0 : sec_cnt + 1'b1;
            sec_tick <= sec_wrap;  // High for the one cycle after the wrap
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt  <= '0;
            scan_tick <= 1'b0;
        end
        else
        begin
            scan_cnt  <= scan_wrap ? '0 : scan_cnt + 1'b1;
            scan_tick <= scan_wrap;
        end
    end

endmodule

`default_nettype wire

/* source/light_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "traffic_settings.svh"

module light_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                sec_tick,
    input  logic                hold,
    output traffic_pkg::phase_t phase,
    output traffic_pkg::count_t count
);

    traffic_pkg::phase_t next_phase;
    traffic_pkg::count_t next_time;
    logic                step;

    assign step = sec_tick && !hold;  // Hold freezes both phase and digit

    // Successor phase and the digit it starts from
    always_comb
    begin
        case (phase)
            traffic_pkg::PH_RED:
            begin
                next_phase = traffic_pkg::PH_GREEN;
                next_time  = traffic_pkg::count_t'(`GREEN_TIME);
            end
            traffic_pkg::PH_GREEN:
            begin
                next_phase = traffic_pkg::PH_YELLOW;
                next_time  = traffic_pkg::count_t'(`YELLOW_TIME);
            end
            default:
            begin
                next_phase = traffic_pkg::PH_RED;
                next_time  = traffic_pkg::count_t'(`RED_TIME);
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            phase <= traffic_pkg::PH_RED;
            count <= traffic_pkg::count_t'(`RED_TIME);
        end
        else if (step)
        begin
            if (count != '0)
            begin
                count <= count - 1'b1;
            end
            else
            begin
                phase <= next_phase;  // Zero is shown for a full second first
                count <= next_time;
            end
        end
    end

endmodule

`default_nettype wire

/* source/digit_glyph_rom.sv */
`timescale 1ns/100ps
`default_nettype none

module digit_glyph_rom (
    input  traffic_pkg::count_t   digit,
    input  display_pkg::row_idx_t row_idx,
    output display_pkg::pattern_t pattern
);

    // Row 0 stays dark so the glyph sits in rows 1..7
    always_comb
    begin
        pattern = 8'b0000_0000;
        case (digit)
            3'd0:
            begin
                case (row_idx)
                    3'd1, 3'd7:                   pattern = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5, 3'd6: pattern = 8'b0100_0010;
                    default:                      pattern = 8'b0000_0000;
                endcase
            end
            3'd1:
            begin
                case (row_idx)
                    3'd1, 3'd2, 3'd4, 3'd5, 3'd6: pattern = 8'b0001_1000;
                    3'd3:                         pattern = 8'b0011_1000;
                    3'd7:                         pattern = 8'b0111_1110;
                    default:                      pattern = 8'b0000_0000;
                endcase
            end
            3'd2:
            begin
                case (row_idx)
                    3'd1:    pattern = 8'b0011_1100;
                    3'd2:    pattern = 8'b0110_0110;
                    3'd3:    pattern = 8'b0000_0110;
                    3'd4:    pattern = 8'b0000_1100;
                    3'd5:    pattern = 8'b0011_0000;
                    3'd6:    pattern = 8'b0110_0000;
                    3'd7:    pattern = 8'b0111_1110;
                    default: pattern = 8'b0000_0000;
                endcase
            end
            3'd3:
            begin
                case (row_idx)
                    3'd1, 3'd7: pattern = 8'b0011_1100;
                    3'd2, 3'd6: pattern = 8'b0110_0110;
                    3'd3, 3'd5: pattern = 8'b0000_0110;
                    3'd4:       pattern = 8'b0001_1100;
                    default:    pattern = 8'b0000_0000;
                endcase
            end
            3'd4:
            begin
                case (row_idx)
                    3'd1, 3'd6, 3'd7: pattern = 8'b0000_1100;
                    3'd2:             pattern = 8'b0001_1100;
                    3'd3:             pattern = 8'b0010_1100;
                    3'd4:             pattern = 8'b0100_1100;
                    3'd5:             pattern = 8'b0111_1110;
                    default:          pattern = 8'b0000_0000;
                endcase
            end
            3'd5:
            begin
                case (row_idx)
                    3'd1:       pattern = 8'b0111_1110;
                    3'd2:       pattern = 8'b0110_0000;
                    3'd3:       pattern = 8'b0111_1100;
                    3'd4, 3'd5: pattern = 8'b0000_0110;
                    3'd6:       pattern = 8'b0110_0110;
                    3'd7:       pattern = 8'b0011_1100;
                    default:    pattern = 8'b0000_0000;
                endcase
            end
            default:
            begin
                pattern = 8'b0000_0000;  // Digits 6 and 7 have no glyph
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/matrix_row_driver.sv */
`timescale 1ns/100ps
`default_nettype none

module matrix_row_driver (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  scan_tick,
    input  traffic_pkg::phase_t   phase,
    input  display_pkg::pattern_t pattern,
    output display_pkg::row_idx_t row_idx,
    output display_pkg::pattern_t row,
    output display_pkg::pattern_t colr,
    output display_pkg::pattern_t colg
);

    display_pkg::row_idx_t cur_idx;
    display_pkg::color_t   color;
    logic                  red_on;
    logic                  green_on;

    // The ROM is addressed one row ahead so the columns land with the row
    assign row_idx = display_pkg::row_idx_t'(cur_idx + 1'b1);

    always_comb
    begin
        case (phase)
            traffic_pkg::PH_RED:   color = display_pkg::COL_RED;
            traffic_pkg::PH_GREEN: color = display_pkg::COL_GREEN;
            default:               color = display_pkg::COL_BOTH;
        endcase
    end

    assign red_on   = (color != display_pkg::COL_GREEN);
    assign green_on = (color != display_pkg::COL_RED);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cur_idx <= '0;
            row     <= 8'b0000_0001;
            colr    <= '0;
            colg    <= '0;
        end
        else if (scan_tick)
        begin
            cur_idx <= row_idx;  // Wraps from 7 to 0 on its own
            row     <= display_pkg::pattern_t'(1) << row_idx;
            colr    <= red_on ? pattern : '0;
            colg    <= green_on ? pattern : '0;
        end
    end

endmodule

`default_nettype wire

/* source/traffic_matrix_top.sv */
`timescale 1ns/100ps
`default_nettype none

module traffic_matrix_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hold,
    output display_pkg::pattern_t row,
    output display_pkg::pattern_t colr,
    output display_pkg::pattern_t colg,
    output traffic_pkg::phase_t   phase,
    output traffic_pkg::count_t   count
);

    logic                  sec_tick;
    logic                  scan_tick;
    display_pkg::row_idx_t row_idx;
    display_pkg::pattern_t pattern;

    tick_generator u_tick_generator (
        .clk       (clk),
        .rst       (rst),
        .sec_tick  (sec_tick),
        .scan_tick (scan_tick)
    );

    light_sequencer u_light_sequencer (
        .clk      (clk),
        .rst      (rst),
        .sec_tick (sec_tick),
        .hold     (hold),
        .phase    (phase),
        .count    (count)
    );

    // The digit on show is the live countdown value
    digit_glyph_rom u_digit_glyph_rom (
        .digit   (count),
        .row_idx (row_idx),
        .pattern (pattern)
    );

    matrix_row_driver u_matrix_row_driver (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .phase     (phase),
        .pattern   (pattern),
        .row_idx   (row_idx),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

endmodule

`default_nettype wire

/* sim/tb_traffic_matrix.sv */
`timescale 1ns/100ps
`default_nettype none
`include "traffic_settings.svh"

module tb_traffic_matrix;

    localparam int LIGHT_CYCLES   = 4;
    localparam int LIGHT_SECONDS  = `RED_TIME + `GREEN_TIME + `YELLOW_TIME + 3;
    localparam int TIMEOUT_CYCLES = 12 * LIGHT_SECONDS * `SEC_DIV * 2 + 16 * `SEC_DIV;

    logic                  clk;
    logic                  rst;
    logic                  hold;
    display_pkg::pattern_t row;
    display_pkg::pattern_t colr;
    display_pkg::pattern_t colg;
    traffic_pkg::phase_t   phase;
    traffic_pkg::count_t   count;

    // Reference model state, one register per observable output
    int                    m_cyc;
    logic                  m_sec_tick;
    logic                  m_scan_tick;
    traffic_pkg::phase_t   m_phase;
    traffic_pkg::count_t   m_count;
    display_pkg::row_idx_t m_idx;
    display_pkg::pattern_t m_row;
    display_pkg::pattern_t m_colr;
    display_pkg::pattern_t m_colg;
    int                    cycles_done;
    logic [15:0]           lfsr_state = 16'd50253;

    traffic_matrix_top u_traffic_matrix_top (
        .clk   (clk),
        .rst   (rst),
        .hold  (hold),
        .row   (row),
        .colr  (colr),
        .colg  (colg),
        .phase (phase),
        .count (count)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0])
        begin
            next = next ^ 16'hB400;  // Taps 16, 14, 13 and 11
        end
        return next;
    endfunction

    // Each digit packed with row 7 in the top byte
    function automatic display_pkg::pattern_t expected_glyph(input traffic_pkg::count_t digit,
                                                             input display_pkg::row_idx_t r);
        logic [63:0] rows;
        case (digit)
            3'd0:    rows = 64'h3C42_4242_4242_3C00;
            3'd1:    rows = 64'h7E18_1818_3818_1800;
            3'd2:    rows = 64'h7E60_300C_0666_3C00;
            3'd3:    rows = 64'h3C66_061C_0666_3C00;
            3'd4:    rows = 64'h0C0C_7E4C_2C1C_0C00;
            3'd5:    rows = 64'h3C66_0606_7C60_7E00;
            default: rows = 64'h0;
        endcase
        return display_pkg::pattern_t'(rows >> {r, 3'b000});
    endfunction

    // Yellow is shown by lighting both channels
    function automatic display_pkg::pattern_t expected_cols(input display_pkg::pattern_t glyph,
                                                            input traffic_pkg::phase_t ph,
                                                            input logic green_channel);
        logic lit;
        if (green_channel)
        begin
            lit = (ph == traffic_pkg::PH_GREEN) || (ph == traffic_pkg::PH_YELLOW);
        end
        else
        begin
            lit = (ph == traffic_pkg::PH_RED) || (ph == traffic_pkg::PH_YELLOW);
        end
        return lit ? glyph : 8'h00;
    endfunction

    function automatic traffic_pkg::phase_t phase_after(input traffic_pkg::phase_t ph);
        case (ph)
            traffic_pkg::PH_RED:   return traffic_pkg::PH_GREEN;
            traffic_pkg::PH_GREEN: return traffic_pkg::PH_YELLOW;
            default:               return traffic_pkg::PH_RED;
        endcase
    endfunction

    function automatic traffic_pkg::count_t reload_time(input traffic_pkg::phase_t ph);
        case (ph)
            traffic_pkg::PH_RED:   return traffic_pkg::count_t'(`RED_TIME);
            traffic_pkg::PH_GREEN: return traffic_pkg::count_t'(`GREEN_TIME);
            default:               return traffic_pkg::count_t'(`YELLOW_TIME);
        endcase
    endfunction

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_phase(input string name, input traffic_pkg::phase_t got,
                               input traffic_pkg::phase_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h expected %h at cycle %0d", name, got, exp, m_cyc);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input string name, input traffic_pkg::count_t got,
                               input traffic_pkg::count_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h expected %h at cycle %0d", name, got, exp, m_cyc);
            stop_with_failure();
        end
    endtask

    task automatic check_cols(input string name, input display_pkg::pattern_t got,
                              input display_pkg::pattern_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h expected %h at cycle %0d", name, got, exp, m_cyc);
            stop_with_failure();
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Model of ticks, sequencer and row scan, cycle 1 is the first edge out of reset
    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            m_cyc       <= 0;
            m_sec_tick  <= 1'b0;
            m_scan_tick <= 1'b0;
            m_phase     <= traffic_pkg::PH_RED;
            m_count     <= traffic_pkg::count_t'(`RED_TIME);
            m_idx       <= '0;
            m_row       <= 8'h01;
            m_colr      <= 8'h00;
            m_colg      <= 8'h00;
            cycles_done <= 0;
        end
        else
        begin
            m_cyc       <= m_cyc + 1;
            m_sec_tick  <= ((m_cyc + 1) % `SEC_DIV) == 0;
            m_scan_tick <= ((m_cyc + 1) % `SCAN_DIV) == 0;
            if (m_sec_tick && !hold)  // A held tick leaves phase and count frozen
            begin
                if (m_count != 3'd0)
                begin
                    m_count <= m_count - 3'd1;
                end
                else
                begin
                    m_phase <= phase_after(m_phase);
                    m_count <= reload_time(phase_after(m_phase));
                    if (m_phase == traffic_pkg::PH_YELLOW)
                    begin
                        cycles_done <= cycles_done + 1;
                    end
                end
            end
            if (m_scan_tick)
            begin
                m_idx  <= m_idx + 3'd1;
                m_row  <= {m_row[6:0], m_row[7]};  // Steps one row and wraps from 8'h80
                m_colr <= expected_cols(expected_glyph(m_count, m_idx + 3'd1), m_phase, 1'b0);
                m_colg <= expected_cols(expected_glyph(m_count, m_idx + 3'd1), m_phase, 1'b1);
            end
        end
    end

    // Hold is redrawn in the middle of each second so it spans the next tick
    always @(posedge clk)
    begin
        if (!rst && (m_cyc % `SEC_DIV) == (`SEC_DIV / 2))
        begin
            hold       <= lfsr_state[0];
            lfsr_state <= lfsr_step(lfsr_state);
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk)
    begin
        check_phase("phase", phase, m_phase);
        check_count("count", count, m_count);
        check_cols("row", row, m_row);
        check_cols("colr", colr, m_colr);
        check_cols("colg", colg, m_colg);
    end

    always @(posedge clk)
    begin
        if (m_cyc >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: %0d light cycles not completed in %0d clock cycles",
                     LIGHT_CYCLES, TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    initial
    begin
        rst  = 1'b1;
        hold = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // Reset state checked against fixed values, independent of the model
        check_cols("row", row, 8'h01);
        check_cols("colr", colr, 8'h00);
        check_cols("colg", colg, 8'h00);
        check_phase("phase", phase, traffic_pkg::PH_RED);
        check_count("count", count, traffic_pkg::count_t'(`RED_TIME));
        wait (cycles_done >= LIGHT_CYCLES);
        @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
source/traffic_pkg.sv
source/display_pkg.sv
source/tick_generator.sv
source/light_sequencer.sv
source/digit_glyph_rom.sv
source/matrix_row_driver.sv
source/traffic_matrix_top.sv
sim/tb_traffic_matrix.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_traffic_matrix
RTL_TOP   ?= traffic_matrix_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing

FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
